//--- rtl/credit_counter.sv
// CREDITS must be at least 1, and returns beyond the initial count are ignored
`timescale 1ns/1ps

module credit_counter #(
   parameter int CREDITS = 2
) (
   input  logic rvvi,
   input  logic rst_n,
   input  logic head_valid,
   input  logic credit_return,
   output logic grant
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   logic [CNT_W-1:0] credits;

   // Send only while the consumer has room
   assign grant = head_valid && (credits != '0);

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         credits <= CNT_W'(CREDITS);
      end else begin
         // Return and grant together leave the count alone
         case ({credit_return, grant})
            2'b10: begin
               if (credits != CNT_W'(CREDITS)) begin
                  credits <= credits + 1'b1;
               end
            end
            2'b01:   credits <= credits - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- rtl/net_event_fifo.sv
// Writer must hold off while not_full is low, and net_id and net_payload mean nothing without net_valid
`timescale 1ns/1ps

module net_event_fifo
   import rvvi_net_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic         rvvi,
   input  logic         rst_n,
   input  logic         ev_push,
   input  net_id_t      ev_id,
   input  net_payload_u ev_payload,
   output logic         not_full,
   output logic         head_valid,
   input  logic         grant,
   output logic         net_valid,
   output net_id_t      net_id,
   output net_payload_u net_payload
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   net_id_t          id_mem  [FIFO_DEPTH];
   net_payload_u     pay_mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Pointer wrap for any depth
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign not_full   = count != CNT_W'(FIFO_DEPTH);
   assign head_valid = count != '0;

   // Head is shown for the granted cycle only
   assign net_valid   = grant;
   assign net_id      = id_mem[rd_ptr];
   assign net_payload = pay_mem[rd_ptr];

   always_ff @(posedge rvvi) begin
      if (ev_push) begin
         id_mem[wr_ptr]  <= ev_id;
         pay_mem[wr_ptr] <= ev_payload;
      end
   end

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (ev_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (grant) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({ev_push, grant})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- rtl/net_event_scheduler.sv
// Interrupt lines must be synchronous to rvvi, and a level that flips back before it is sent is dropped
`timescale 1ns/1ps

module net_event_scheduler
   import rvvi_net_pkg::*;
(
   input  logic             rvvi,
   input  logic             rst_n,
   input  logic             accept,
   input  logic             q_intr,
   input  logic             q_interrupt,
   input  logic [10:0]      q_cause,
   input  logic             q_trap_fault,
   input  logic             q_nmip,
   input  logic             q_halt_target,
   input  logic [IRQ_W-1:0] irq,
   input  logic             not_full,
   output logic             ev_push,
   output net_id_t          ev_id,
   output net_payload_u     ev_payload
);

   logic             nmi_hit;
   logic             nmi_tgt;
   logic [10:0]      cause_tgt;
   logic             ifault_tgt;
   logic             halt_tgt;
   logic             nmi_rep;
   logic [10:0]      cause_rep;
   logic             ifault_rep;
   logic             halt_rep;
   logic [IRQ_W-1:0] irq_rep;
   logic [IRQ_W-1:0] irq_diff;
   logic [4:0]       irq_line;
   logic             ev_found;

   // Bus error NMI or pending NMI on the retired instruction
   assign nmi_hit = (q_intr && q_interrupt &&
                     (q_cause == NMI_LOAD_CAUSE || q_cause == NMI_STORE_CAUSE)) || q_nmip;

   ////////////////////
   // Target levels
   ////////////////////

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         nmi_tgt    <= 1'b0;
         cause_tgt  <= '0;
         ifault_tgt <= 1'b0;
         halt_tgt   <= 1'b0;
      end else if (accept) begin
         nmi_tgt    <= nmi_hit;
         ifault_tgt <= q_trap_fault;
         // Halt stays up until a retirement outside the debug request
         halt_tgt   <= q_halt_target;
         if (nmi_hit) begin
            cause_tgt <= q_cause;
         end
      end
   end

   // Monitored lines that differ from what was last sent
   assign irq_diff = (irq ^ irq_rep) & irq_monitor_mask;

   // Lowest changed line wins
   always_comb begin
      irq_line = '0;
      for (int i = IRQ_W - 1; i >= 0; i--) begin
         if (irq_diff[i]) begin
            irq_line = 5'(i);
         end
      end
   end

   ////////////////////
   // Event selection
   ////////////////////

   always_comb begin
      ev_found   = 1'b1;
      ev_id      = NET_NMI_CAUSE;
      ev_payload = '0;
      if (nmi_tgt && !nmi_rep && (cause_tgt != cause_rep)) begin
         // Cause goes out ahead of the NMI rise
         ev_payload.cause = cause_tgt;
      end else if (nmi_tgt != nmi_rep) begin
         ev_id                = NET_NMI;
         ev_payload.lvl.value = nmi_tgt;
      end else if (ifault_tgt != ifault_rep) begin
         ev_id                = NET_IFAULT;
         ev_payload.lvl.value = ifault_tgt;
      end else if (halt_tgt != halt_rep) begin
         ev_id                = NET_HALTREQ;
         ev_payload.lvl.value = halt_tgt;
      end else if (irq_diff != '0) begin
         ev_id                = NET_IRQ;
         ev_payload.lvl.line  = irq_line;
         ev_payload.lvl.value = irq[irq_line];
      end else begin
         ev_found = 1'b0;
      end
   end

   assign ev_push = ev_found && not_full;

   ////////////////////
   // Reported levels
   ////////////////////

   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         nmi_rep    <= 1'b0;
         cause_rep  <= '0;
         ifault_rep <= 1'b0;
         halt_rep   <= 1'b0;
         irq_rep    <= '0;
      end else if (ev_push) begin
         case (ev_id)
            NET_NMI_CAUSE: cause_rep <= ev_payload.cause;
            NET_NMI:       nmi_rep <= ev_payload.lvl.value;
            NET_IFAULT:    ifault_rep <= ev_payload.lvl.value;
            NET_HALTREQ:   halt_rep <= ev_payload.lvl.value;
            NET_IRQ:       irq_rep[ev_payload.lvl.line] <= ev_payload.lvl.value;
            default:       ;
         endcase
      end
   end

endmodule

//--- rtl/rvvi_bridge.sv
// Single hart bridge with a credit-based net event stream whose latency varies under back-pressure
`timescale 1ns/1ps

module rvvi_bridge
   import rvvi_trace_pkg::*;
   import rvvi_net_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int CREDITS    = 2
) (
   input  logic             rvvi,
   input  logic             rst_n,
   input  logic             rvfi_valid,
   input  order_t           rvfi_order,
   input  xlen_t            rvfi_insn,
   input  xlen_t            rvfi_pc_rdata,
   input  xlen_t            rvfi_pc_wdata,
   input  logic [1:0]       rvfi_mode,
   input  logic [1:0]       rvfi_ixl,
   input  logic             rvfi_intr,
   input  logic             intr_interrupt,
   input  logic [10:0]      intr_cause,
   input  logic             trap_trap,
   input  logic             trap_exception,
   input  logic [5:0]       trap_cause,
   input  logic             rvfi_nmip,
   input  logic [2:0]       rvfi_dbg,
   input  logic             rvfi_dbg_mode,
   input  reg_idx_t         rd_addr,
   input  xlen_t            rd_wdata,
   input  logic             csr_valid,
   input  csr_idx_t         csr_sel,
   input  xlen_t            csr_rdata,
   input  xlen_t            csr_wdata,
   input  xlen_t            csr_wmask,
   input  logic [IRQ_W-1:0] irq,
   output logic             trace_valid,
   output order_t           trace_order,
   output xlen_t            trace_insn,
   output xlen_t            trace_pc_rdata,
   output xlen_t            trace_pc_wdata,
   output logic [1:0]       trace_mode,
   output logic [1:0]       trace_ixl,
   output logic             trace_intr,
   output logic             trace_trap,
   output reg_mask_t        x_wb,
   output xlen_t [31:0]     x_wdata,
   output csr_idx_t         trace_csr_sel,
   output xlen_t            trace_csr_value,
   output logic             trace_csr_wb,
   input  logic             credit_return,
   output logic             net_valid,
   output net_id_t          net_id,
   output net_payload_u     net_payload
);

   logic         accept;
   logic         q_intr;
   logic         q_interrupt;
   logic [10:0]  q_cause;
   logic         q_trap_fault;
   logic         q_nmip;
   logic         q_halt_target;
   logic         ev_push;
   net_id_t      ev_id;
   net_payload_u ev_payload;
   logic         not_full;
   logic         head_valid;
   logic         grant;

   ////////////////////
   // Retirement trace
   ////////////////////

   trace_capture u_trace_capture (
      .rvvi            (rvvi),
      .rst_n           (rst_n),
      .rvfi_valid      (rvfi_valid),
      .rvfi_order      (rvfi_order),
      .rvfi_insn       (rvfi_insn),
      .rvfi_pc_rdata   (rvfi_pc_rdata),
      .rvfi_pc_wdata   (rvfi_pc_wdata),
      .rvfi_mode       (rvfi_mode),
      .rvfi_ixl        (rvfi_ixl),
      .rvfi_intr       (rvfi_intr),
      .intr_interrupt  (intr_interrupt),
      .intr_cause      (intr_cause),
      .trap_trap       (trap_trap),
      .trap_exception  (trap_exception),
      .trap_cause      (trap_cause),
      .rvfi_nmip       (rvfi_nmip),
      .rvfi_dbg        (rvfi_dbg),
      .rvfi_dbg_mode   (rvfi_dbg_mode),
      .rd_addr         (rd_addr),
      .rd_wdata        (rd_wdata),
      .csr_valid       (csr_valid),
      .csr_sel         (csr_sel),
      .csr_rdata       (csr_rdata),
      .csr_wdata       (csr_wdata),
      .csr_wmask       (csr_wmask),
      .trace_valid     (trace_valid),
      .trace_order     (trace_order),
      .trace_insn      (trace_insn),
      .trace_pc_rdata  (trace_pc_rdata),
      .trace_pc_wdata  (trace_pc_wdata),
      .trace_mode      (trace_mode),
      .trace_ixl       (trace_ixl),
      .trace_intr      (trace_intr),
      .trace_trap      (trace_trap),
      .x_wb            (x_wb),
      .x_wdata         (x_wdata),
      .trace_csr_sel   (trace_csr_sel),
      .trace_csr_value (trace_csr_value),
      .trace_csr_wb    (trace_csr_wb),
      .accept          (accept),
      .q_intr          (q_intr),
      .q_interrupt     (q_interrupt),
      .q_cause         (q_cause),
      .q_trap_fault    (q_trap_fault),
      .q_nmip          (q_nmip),
      .q_halt_target   (q_halt_target)
   );

   ////////////////////
   // Net event path
   ////////////////////

   net_event_scheduler u_net_event_scheduler (
      .rvvi          (rvvi),
      .rst_n         (rst_n),
      .accept        (accept),
      .q_intr        (q_intr),
      .q_interrupt   (q_interrupt),
      .q_cause       (q_cause),
      .q_trap_fault  (q_trap_fault),
      .q_nmip        (q_nmip),
      .q_halt_target (q_halt_target),
      .irq           (irq),
      .not_full      (not_full),
      .ev_push       (ev_push),
      .ev_id         (ev_id),
      .ev_payload    (ev_payload)
   );

   net_event_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_net_event_fifo (
      .rvvi        (rvvi),
      .rst_n       (rst_n),
      .ev_push     (ev_push),
      .ev_id       (ev_id),
      .ev_payload  (ev_payload),
      .not_full    (not_full),
      .head_valid  (head_valid),
      .grant       (grant),
      .net_valid   (net_valid),
      .net_id      (net_id),
      .net_payload (net_payload)
   );

   credit_counter #(
      .CREDITS (CREDITS)
   ) u_credit_counter (
      .rvvi          (rvvi),
      .rst_n         (rst_n),
      .head_valid    (head_valid),
      .credit_return (credit_return),
      .grant         (grant)
   );

endmodule

//--- rtl/rvvi_net_pkg.sv
// Net event encoding for the reference model; the IRQ line index in the payload must stay below 32
package rvvi_net_pkg;

   // Width of the core interrupt vector
   localparam int IRQ_W = 32;

   // Software, timer and external lines plus the sixteen local lines
   localparam logic [IRQ_W-1:0] irq_monitor_mask = 32'hFFFF_0888;

   // Load and store bus error causes
   localparam logic [10:0] NMI_LOAD_CAUSE  = 11'd1024;
   localparam logic [10:0] NMI_STORE_CAUSE = 11'd1025;

   typedef enum logic [2:0] {
      NET_NMI_CAUSE,
      NET_NMI,
      NET_IFAULT,
      NET_HALTREQ,
      NET_IRQ
   } net_id_t;

   // Level view used by every net except NET_NMI_CAUSE
   typedef struct packed {
      logic [4:0] rsvd;
      logic [4:0] line;
      logic       value;
   } net_level_t;

   typedef union packed {
      net_level_t  lvl;
      logic [10:0] cause;
   } net_payload_u;

endpackage

//--- rtl/rvvi_trace_pkg.sv
// Trace types for a single RV32 hart; only eight CSRs are tracked and no FP or vector state
package rvvi_trace_pkg;

   ////////////////////
   // Word widths
   ////////////////////

   typedef logic [31:0] xlen_t;
   typedef logic [63:0] order_t;
   typedef logic [4:0]  reg_idx_t;

   // One bit per general register
   typedef logic [31:0] reg_mask_t;

   // Index into the tracked CSR table
   typedef logic [2:0]  csr_idx_t;

   ////////////////////
   // Tracked CSRs
   ////////////////////

   // Addresses of the tracked CSRs in csr_sel order
   localparam logic [11:0] tracked_csr_addr [8] = '{
      12'h300,
      12'h301,
      12'h304,
      12'h305,
      12'h340,
      12'h341,
      12'h342,
      12'h343
   };

   // Instruction bus fault, raised outside the core
   localparam logic [5:0] FETCH_FAULT_CAUSE = 6'd48;

endpackage

//--- rtl/trace_capture.sv
// Retirement with order 0 straight after reset is taken as already seen, one register write per retirement
`timescale 1ns/1ps

module trace_capture
   import rvvi_trace_pkg::*;
(
   input  logic         rvvi,
   input  logic         rst_n,
   input  logic         rvfi_valid,
   input  order_t       rvfi_order,
   input  xlen_t        rvfi_insn,
   input  xlen_t        rvfi_pc_rdata,
   input  xlen_t        rvfi_pc_wdata,
   input  logic [1:0]   rvfi_mode,
   input  logic [1:0]   rvfi_ixl,
   input  logic         rvfi_intr,
   input  logic         intr_interrupt,
   input  logic [10:0]  intr_cause,
   input  logic         trap_trap,
   input  logic         trap_exception,
   input  logic [5:0]   trap_cause,
   input  logic         rvfi_nmip,
   input  logic [2:0]   rvfi_dbg,
   input  logic         rvfi_dbg_mode,
   input  reg_idx_t     rd_addr,
   input  xlen_t        rd_wdata,
   input  logic         csr_valid,
   input  csr_idx_t     csr_sel,
   input  xlen_t        csr_rdata,
   input  xlen_t        csr_wdata,
   input  xlen_t        csr_wmask,
   output logic         trace_valid,
   output order_t       trace_order,
   output xlen_t        trace_insn,
   output xlen_t        trace_pc_rdata,
   output xlen_t        trace_pc_wdata,
   output logic [1:0]   trace_mode,
   output logic [1:0]   trace_ixl,
   output logic         trace_intr,
   output logic         trace_trap,
   output reg_mask_t    x_wb,
   output xlen_t [31:0] x_wdata,
   output csr_idx_t     trace_csr_sel,
   output xlen_t        trace_csr_value,
   output logic         trace_csr_wb,
   output logic         accept,
   output logic         q_intr,
   output logic         q_interrupt,
   output logic [10:0]  q_cause,
   output logic         q_trap_fault,
   output logic         q_nmip,
   output logic         q_halt_target
);

   logic  take;
   logic  valid_q;
   logic  fault_q;
   xlen_t rd_data_q;
   xlen_t csr_merged;
   xlen_t shadow [8];

   // New retirement only when the order moves on
   assign take = rvfi_valid && (rvfi_order != trace_order);

   // Written bits from wdata, the rest from rdata
   assign csr_merged = (csr_wdata & csr_wmask) | (csr_rdata & ~csr_wmask);

   ////////////////////
   // Control state
   ////////////////////

   // trace_order doubles as the last accepted order
   always_ff @(posedge rvvi or negedge rst_n) begin
      if (!rst_n) begin
         valid_q       <= 1'b0;
         trace_order   <= '0;
         x_wb          <= '0;
         trace_csr_wb  <= 1'b0;
         q_halt_target <= 1'b0;
         for (int i = 0; i < 8; i++) begin
            shadow[i] <= '0;
         end
      end else begin
         valid_q      <= take;
         x_wb         <= take ? (reg_mask_t'(1) << rd_addr) : '0;
         trace_csr_wb <= 1'b0;
         if (take) begin
            trace_order   <= rvfi_order;
            // Halt request as seen by the retired instruction
            q_halt_target <= (rvfi_dbg == 3'd3) && rvfi_dbg_mode;
            if (csr_valid) begin
               trace_csr_wb    <= csr_merged != shadow[csr_sel];
               shadow[csr_sel] <= csr_merged;
            end
         end
      end
   end

   ////////////////////
   // Retirement payload
   ////////////////////

   always_ff @(posedge rvvi) begin
      if (take) begin
         trace_insn      <= rvfi_insn;
         trace_pc_rdata  <= rvfi_pc_rdata;
         trace_pc_wdata  <= rvfi_pc_wdata;
         trace_mode      <= rvfi_mode;
         trace_ixl       <= rvfi_ixl;
         rd_data_q       <= (rd_addr != '0) ? rd_wdata : '0;
         trace_csr_sel   <= csr_sel;
         trace_csr_value <= csr_merged;
         q_intr          <= rvfi_intr;
         q_interrupt     <= intr_interrupt;
         q_cause         <= intr_cause;
         q_nmip          <= rvfi_nmip;
         // Only the external fetch fault counts as a trap
         fault_q         <= trap_trap && trap_exception && (trap_cause == FETCH_FAULT_CAUSE);
      end
   end

   // Data shows only at the written index
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         x_wdata[i] = x_wb[i] ? rd_data_q : '0;
      end
   end

   assign trace_valid  = valid_q;
   assign accept       = valid_q;
   assign trace_intr   = q_intr;
   assign trace_trap   = fault_q;
   assign q_trap_fault = fault_q;

endmodule

//--- rvvi_bridge.f
rtl/rvvi_trace_pkg.sv
rtl/rvvi_net_pkg.sv
rtl/credit_counter.sv
rtl/net_event_fifo.sv
rtl/net_event_scheduler.sv
rtl/trace_capture.sv
rtl/rvvi_bridge.sv
test/tb_rvvi_bridge.sv

//--- test/tb_rvvi_bridge.sv
// Testbench for one hart; retirement orders start at 1 and irq changes are spaced until events drain
`timescale 1ns/1ps

module tb_rvvi_bridge
   import rvvi_trace_pkg::*;
   import rvvi_net_pkg::*;
();

   localparam int FIFO_DEPTH = 4;
   localparam int CREDITS    = 2;
   localparam int LIMIT      = 400;

   typedef struct packed {
      order_t     order;
      xlen_t      insn;
      xlen_t      pc_r;
      xlen_t      pc_w;
      logic [1:0] mode;
      logic [1:0] ixl;
      logic       intr;
      logic       trap;
      reg_idx_t   rd;
      xlen_t      rdata;
      csr_idx_t   sel;
      xlen_t      csr_val;
      logic       csr_wb;
   } trace_rec_t;

   logic rvvi = 1'b0;
   logic rst_n;
   logic rvfi_valid, rvfi_intr, intr_interrupt, trap_trap, trap_exception;
   logic rvfi_nmip, rvfi_dbg_mode, csr_valid, credit_return;
   order_t rvfi_order;
   xlen_t rvfi_insn, rvfi_pc_rdata, rvfi_pc_wdata, rd_wdata;
   xlen_t csr_rdata, csr_wdata, csr_wmask;
   logic [1:0] rvfi_mode, rvfi_ixl;
   logic [10:0] intr_cause;
   logic [5:0] trap_cause;
   logic [2:0] rvfi_dbg;
   reg_idx_t rd_addr;
   csr_idx_t csr_sel;
   logic [IRQ_W-1:0] irq;
   logic trace_valid, trace_intr, trace_trap, trace_csr_wb, net_valid;
   order_t trace_order;
   xlen_t trace_insn, trace_pc_rdata, trace_pc_wdata, trace_csr_value;
   logic [1:0] trace_mode, trace_ixl;
   reg_mask_t x_wb;
   xlen_t [31:0] x_wdata;
   csr_idx_t trace_csr_sel;
   net_id_t net_id;
   net_payload_u net_payload;

   integer seed;
   int err_count = 0;
   int check_count = 0;
   int got_count = 0;
   int cycle_count = 0;
   logic hold_credits = 1'b0;
   trace_rec_t trace_exp [$];
   int trace_due [$];
   logic [13:0] ev_exp [$];
   int credit_due [$];
   order_t last_order = '0;
   xlen_t shadow [8];
   // Model of target and reported net levels
   logic nmi_t, nmi_r, ifault_t, ifault_r, halt_t, halt_r;
   logic [10:0] cause_t, cause_r;
   logic [IRQ_W-1:0] irq_t, irq_r;
   // Levels as seen on the net event output
   logic obs_nmi, obs_ifault, obs_halt;
   logic [10:0] obs_cause;
   logic [IRQ_W-1:0] obs_irq;

   rvvi_bridge #(.FIFO_DEPTH(FIFO_DEPTH), .CREDITS(CREDITS)) u_rvvi_bridge (.*);

   always #5 rvvi = ~rvvi;

   always @(posedge rvvi) cycle_count <= cycle_count + 1;

   // Each bit comes from wdata where the mask is set, else from rdata
   function automatic xlen_t csr_merge(input xlen_t rdata, input xlen_t wdata, input xlen_t wmask);
      xlen_t v;
      for (int i = 0; i < 32; i++) begin
         v[i] = wmask[i] ? wdata[i] : rdata[i];
      end
      return v;
   endfunction

   function automatic reg_mask_t one_hot(input reg_idx_t idx);
      reg_mask_t m;
      for (int i = 0; i < 32; i++) begin
         m[i] = (i == idx);
      end
      return m;
   endfunction

   function automatic logic [13:0] level_event(input net_id_t id, input logic [4:0] line,
                                               input logic v);
      return {id, 5'd0, line, v};
   endfunction

   // Expected events in priority order, stopping after limit entries
   function automatic void queue_level_events(input int limit);
      int n;
      n = 0;
      if (n < limit && nmi_t && !nmi_r && cause_t != cause_r) begin
         ev_exp.push_back({NET_NMI_CAUSE, cause_t});
         cause_r = cause_t;
         n++;
      end
      if (n < limit && nmi_t != nmi_r) begin
         ev_exp.push_back(level_event(NET_NMI, 5'd0, nmi_t));
         nmi_r = nmi_t;
         n++;
      end
      if (n < limit && ifault_t != ifault_r) begin
         ev_exp.push_back(level_event(NET_IFAULT, 5'd0, ifault_t));
         ifault_r = ifault_t;
         n++;
      end
      if (n < limit && halt_t != halt_r) begin
         ev_exp.push_back(level_event(NET_HALTREQ, 5'd0, halt_t));
         halt_r = halt_t;
         n++;
      end
      for (int i = 0; i < IRQ_W; i++) begin
         if (n < limit && irq_monitor_mask[i] && irq_t[i] != irq_r[i]) begin
            ev_exp.push_back(level_event(NET_IRQ, 5'(i), irq_t[i]));
            irq_r[i] = irq_t[i];
            n++;
         end
      end
   endfunction

   function automatic void check_word(input string what, input logic [63:0] got,
                                      input logic [63:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endfunction

   task automatic abort_run(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((ev_exp.size() != 0 || credit_due.size() != 0) && n < LIMIT) begin
         @(posedge rvvi);
         n++;
      end
      if (n >= LIMIT) begin
         abort_run("net events and credit returns to drain");
      end
   endtask

   // kind: 0 plain, 1 load NMI, 2 store NMI, 3 pending NMI, 4 fetch fault, 5 halt request,
   // 6 NMI and fetch fault causes with only one of their flags, debug mode with any dbg
   task automatic retire(input order_t ord, input logic vld, input int kind);
      trace_rec_t rec;
      logic intr_b, int_b, trp, exc, nmip, hit, dm;
      logic [10:0] cause;
      logic [5:0] tcause;
      logic [2:0] dbg;
      xlen_t crd, cwd, cwm;
      logic cv;
      rec.order = ord;
      rec.insn = $random(seed);
      rec.pc_r = $random(seed);
      rec.pc_w = $random(seed);
      rec.mode = $random(seed);
      rec.ixl = $random(seed);
      rec.rd = $random(seed);
      rec.rdata = $random(seed);
      rec.sel = $random(seed);
      crd = $random(seed) & 3;
      cwd = $random(seed) & 3;
      cwm = $random(seed) & 3;
      cv = $random(seed);
      intr_b = (kind == 1 || kind == 2) ? 1'b1 : $random(seed);
      int_b = (kind == 1 || kind == 2) ? 1'b1 : (kind == 6) ? !intr_b : $random(seed);
      cause = (kind == 1) ? 11'd1024 : (kind == 2) ? 11'd1025 :
              (kind == 6) ? (11'd1024 + ($random(seed) & 1)) : ($random(seed) & 11'h3FF);
      trp = (kind == 4) ? 1'b1 : $random(seed);
      exc = (kind == 4) ? 1'b1 : (kind == 6) ? !trp : $random(seed);
      tcause = (kind == 4 || kind == 6) ? 6'd48 : ($random(seed) & 6'h1F);
      nmip = (kind == 3);
      dbg = (kind == 5) ? 3'd3 : $random(seed);
      dm = (kind == 5 || kind == 6);
      @(posedge rvvi);
      rvfi_valid <= vld;
      rvfi_order <= ord;
      rvfi_insn <= rec.insn;
      rvfi_pc_rdata <= rec.pc_r;
      rvfi_pc_wdata <= rec.pc_w;
      rvfi_mode <= rec.mode;
      rvfi_ixl <= rec.ixl;
      rvfi_intr <= intr_b;
      intr_interrupt <= int_b;
      intr_cause <= cause;
      trap_trap <= trp;
      trap_exception <= exc;
      trap_cause <= tcause;
      rvfi_nmip <= nmip;
      rvfi_dbg <= dbg;
      rvfi_dbg_mode <= dm;
      rd_addr <= rec.rd;
      rd_wdata <= rec.rdata;
      csr_valid <= cv;
      csr_sel <= rec.sel;
      csr_rdata <= crd;
      csr_wdata <= cwd;
      csr_wmask <= cwm;
      if (vld && ord != last_order) begin
         last_order = ord;
         rec.intr = intr_b;
         rec.trap = trp && exc && tcause == 6'd48;
         rec.csr_val = csr_merge(crd, cwd, cwm);
         rec.csr_wb = cv && rec.csr_val != shadow[rec.sel];
         if (cv) begin
            shadow[rec.sel] = rec.csr_val;
         end
         trace_exp.push_back(rec);
         // Record shows in the cycle after the accepting edge
         trace_due.push_back(cycle_count + 2);
         hit = (intr_b && int_b && (cause == 11'd1024 || cause == 11'd1025)) || nmip;
         nmi_t = hit;
         if (hit) begin
            cause_t = cause;
         end
         ifault_t = rec.trap;
         halt_t = dbg == 3'd3 && dm;
         queue_level_events(100);
      end
      @(posedge rvvi);
      rvfi_valid <= 1'b0;
      rvfi_nmip <= 1'b0;
      rvfi_dbg <= 3'd0;
      rvfi_dbg_mode <= 1'b0;
      repeat (3) @(posedge rvvi);
      wait_drained();
   endtask

   task automatic drive_irq(input logic [IRQ_W-1:0] value, input int limit);
      @(posedge rvvi);
      irq <= value;
      irq_t = value & irq_monitor_mask;
      queue_level_events(limit);
   endtask

   ////////////////////
   // Trace check
   ////////////////////

   always @(negedge rvvi) begin
      trace_rec_t r;
      if (rst_n && trace_valid) begin
         if (trace_exp.size() == 0) begin
            err_count++;
            $display("error at %0t ns: trace_valid without an accepted retirement", $time);
         end else begin
            r = trace_exp.pop_front();
            check_word("trace latency in cycles", cycle_count, trace_due.pop_front());
            check_word("trace_order", trace_order, r.order);
            check_word("trace_insn", trace_insn, r.insn);
            check_word("trace_pc_rdata", trace_pc_rdata, r.pc_r);
            check_word("trace_pc_wdata", trace_pc_wdata, r.pc_w);
            check_word("trace_mode", trace_mode, r.mode);
            check_word("trace_ixl", trace_ixl, r.ixl);
            check_word("trace_intr", trace_intr, r.intr);
            check_word("trace_trap", trace_trap, r.trap);
            check_word("x_wb", x_wb, one_hot(r.rd));
            for (int i = 0; i < 32; i++) begin
               check_word("x_wdata", x_wdata[i], (i == r.rd && r.rd != 0) ? r.rdata : 0);
            end
            check_word("trace_csr_sel", trace_csr_sel, r.sel);
            check_word($sformatf("trace_csr_value of CSR %h", tracked_csr_addr[r.sel]),
                       trace_csr_value, r.csr_val);
            check_word($sformatf("trace_csr_wb of CSR %h", tracked_csr_addr[r.sel]),
                       trace_csr_wb, r.csr_wb);
         end
      end
   end

   ////////////////////
   // Net event check
   ////////////////////

   always @(negedge rvvi) begin
      if (rst_n && net_valid) begin
         got_count++;
         credit_due.push_back(cycle_count + 1 + ($unsigned($random(seed)) % 4));
         case (net_id)
            NET_NMI_CAUSE: obs_cause = net_payload.cause;
            NET_NMI:       obs_nmi = net_payload.lvl.value;
            NET_IFAULT:    obs_ifault = net_payload.lvl.value;
            NET_HALTREQ:   obs_halt = net_payload.lvl.value;
            default:       obs_irq[net_payload.lvl.line] = net_payload.lvl.value;
         endcase
         if (ev_exp.size() == 0) begin
            err_count++;
            $display("error at %0t ns: unexpected net event id %0d", $time, net_id);
         end else begin
            check_word("net event", {net_id, net_payload}, ev_exp.pop_front());
         end
      end
   end

   // Consumer frees one event per cycle once its delay has passed
   always @(posedge rvvi) begin
      if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle_count) begin
         credit_return <= 1'b1;
         void'(credit_due.pop_front());
      end else begin
         credit_return <= 1'b0;
      end
   end

   initial begin
      order_t ord;
      int held;
      seed = 67;
      {rvfi_valid, rvfi_intr, intr_interrupt, trap_trap, trap_exception} = '0;
      {rvfi_nmip, rvfi_dbg_mode, csr_valid, credit_return} = '0;
      {rvfi_order, rvfi_insn, rvfi_pc_rdata, rvfi_pc_wdata, rd_wdata} = '0;
      {csr_rdata, csr_wdata, csr_wmask, rvfi_mode, rvfi_ixl} = '0;
      {intr_cause, trap_cause, rvfi_dbg, rd_addr, csr_sel, irq} = '0;
      {nmi_t, nmi_r, ifault_t, ifault_r, halt_t, halt_r, cause_t, cause_r, irq_t, irq_r} = '0;
      {obs_nmi, obs_ifault, obs_halt, obs_cause, obs_irq} = '0;
      for (int i = 0; i < 8; i++) begin
         shadow[i] = '0;
      end
      rst_n = 1'b0;
      repeat (2) @(posedge rvvi);
      rst_n <= 1'b1;

      // Plain retirements, a repeated order with an NMI and a low valid with a halt request
      ord = 1;
      for (int i = 0; i < 30; i++) begin
         if (i % 6 == 5) begin
            retire(last_order, 1'b1, 1);
         end else if (i % 6 == 4) begin
            retire(ord, 1'b0, 5);
         end else begin
            retire(ord, 1'b1, (i % 6 == 3) ? 6 : 0);
            ord++;
         end
      end

      // NMI, fetch fault and halt levels
      for (int k = 1; k <= 5; k++) begin
         retire(ord, 1'b1, k);
         retire(ord + 1, 1'b1, 0);
         ord += 2;
      end
      retire(ord, 1'b1, 1);
      retire(ord + 1, 1'b1, 1);
      retire(ord + 2, 1'b1, 0);
      ord += 3;

      ////////////////////
      // Interrupt lines
      ////////////////////

      for (int i = 0; i < 10; i++) begin
         drive_irq($random(seed), 100);
         wait_drained();
         drive_irq(irq ^ ~irq_monitor_mask, 100);
         wait_drained();
      end
      drive_irq('0, 100);
      wait_drained();
      repeat (4) @(posedge rvvi);

      // Back-pressure with a coalesced line
      hold_credits <= 1'b1;
      held = got_count;
      drive_irq(32'h001F_0888, CREDITS + FIFO_DEPTH);
      repeat (20) @(posedge rvvi);
      check_word("events sent without credit", got_count - held, CREDITS);
      drive_irq(32'h000F_0880, 100);
      repeat (10) @(posedge rvvi);
      check_word("events sent without credit", got_count - held, CREDITS);
      hold_credits <= 1'b0;
      wait_drained();
      repeat (4) @(posedge rvvi);

      check_word("pending trace records", trace_exp.size(), 0);
      check_word("final NMI level", obs_nmi, nmi_t);
      check_word("final NMI cause", obs_cause, cause_t);
      check_word("final fetch fault level", obs_ifault, ifault_t);
      check_word("final halt level", obs_halt, halt_t);
      check_word("final irq levels", obs_irq & irq_monitor_mask, irq_t);

      $display("Checks: %0d, errors: %0d, net events: %0d", check_count, err_count, got_count);
      if (err_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
